// ==== hdl/pcie_cfg_clear_timer.sv ====
// interval counter pacing the auto command/status write
`default_nettype none
`include "pcie_cfg_defs.svh"

module pcie_cfg_clear_timer (
    input  wire                     i_clk_pcie,
    input  wire                     i_rst,
    input  wire                     i_enable,      // either auto enable set
    input  wire                     i_quiet,       // engine idle, nothing pending
    input  wire [`CFG_DATA_W-1:0]   i_period,
    output logic                    o_fire
);

    logic [`CFG_DATA_W-1:0] count_q;
    logic                   expired;

    // >= so a period lowered below the count still fires
    assign expired = (count_q >= i_period);

    // only fires while quiet, so the engine is always free to take it
    assign o_fire  = i_enable & i_quiet & expired;

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst || !i_enable)
            count_q <= '0;                          // both enables off restarts
        else if (i_quiet)
        begin
            if (expired)
                count_q <= '0;                      // pulse and restart
            else
                count_q <= count_q + 1'b1;
        end
        // not quiet: hold count
    end

endmodule

`default_nettype wire

// ==== hdl/pcie_cfg_defs.svh ====
// widths, reset values and auto command/status write constants
// for the configuration management block
`ifndef PCIE_CFG_DEFS_SVH
`define PCIE_CFG_DEFS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define CFG_APB_AW                 8            // apb byte address
`define CFG_DATA_W                 32           // apb and cfg_mgmt data
`define CFG_DWADDR_W               10           // config space dword address
`define CFG_BE_W                   4            // byte enables per dword

// ------------------------------------------------------------
// reset values
// ------------------------------------------------------------
`define CFG_MAGIC                  32'h2301_6745 // id word, read only
`define CFG_CLEAR_PERIOD_DEFAULT   32'd62500     // 1 ms at 62.5 MHz
`define CFG_BE_RESET               4'hF          // all bytes on

// ------------------------------------------------------------
// auto command/status write
// ------------------------------------------------------------
`define CFG_CMDSTAT_DWADDR         10'd1         // command + status dword
`define CFG_CMD_SET_BITS           16'h0406      // mem space, bus master, intx off
`define CFG_STAT_CLEAR_BITS        16'hFF00      // error flags in status

`endif

// ==== hdl/pcie_cfg_mgmt_fsm.sv ====
// cfg_mgmt engine: accepts host or auto requests, holds enable until done,
// captures the result
`default_nettype none
`include "pcie_cfg_defs.svh"

module pcie_cfg_mgmt_fsm import pcie_cfg_reg_pkg::*, pcie_cfg_mgmt_pkg::*; (
    input  wire                       i_clk_pcie,
    input  wire                       i_rst,
    pcie_cfg_mgmt_if.seq              mgmt,
    input  wire                       i_fire,
    input  ctrl_t                     i_ctrl,
    output logic                      o_quiet,
    output logic                      o_cfg_mgmt_rd_en,
    output logic                      o_cfg_mgmt_wr_en,
    output logic [`CFG_DATA_W-1:0]    o_cfg_mgmt_di,
    output logic [`CFG_DWADDR_W-1:0]  o_cfg_mgmt_dwaddr,
    output logic [`CFG_BE_W-1:0]      o_cfg_mgmt_byte_en,
    output logic                      o_cfg_mgmt_wr_readonly,
    output logic                      o_cfg_mgmt_wr_rw1c_as_rw,
    input  wire                       i_cfg_mgmt_rd_wr_done,
    input  wire [`CFG_DATA_W-1:0]     i_cfg_mgmt_do
);

    mgmt_state_e state_q;
    mgmt_req_t   req_q;                                // held for whole access
    mgmt_req_t   auto_req;
    logic        idle;
    logic        res_valid_q;

    assign idle     = (state_q == ST_IDLE);
    assign mgmt.ack = idle & (mgmt.req_op != OP_NONE);
    assign o_quiet  = idle & (mgmt.req_op == OP_NONE);
    assign mgmt.busy      = ~idle;
    assign mgmt.res_valid = res_valid_q;

    // command bits in bytes 1:0, status clear in byte 3
    assign auto_req.dwaddr      = `CFG_CMDSTAT_DWADDR;
    assign auto_req.di          = {`CFG_STAT_CLEAR_BITS, `CFG_CMD_SET_BITS};
    assign auto_req.byte_en     = {i_ctrl.status_clear_en, 1'b0,
                                   i_ctrl.command_set_en, i_ctrl.command_set_en};
    assign auto_req.wr_readonly = 1'b0;
    assign auto_req.rw1c_as_rw  = 1'b0;

    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            state_q     <= ST_IDLE;
            res_valid_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (mgmt.req_op == OP_READ)
                        state_q <= ST_READ;
                    else if (mgmt.req_op == OP_WRITE || i_fire)
                        state_q <= ST_WRITE;               // host write or auto write
                    if (mgmt.ack || i_fire)
                        res_valid_q <= 1'b0;
                end
                ST_READ, ST_WRITE:
                begin
                    if (i_cfg_mgmt_rd_wr_done)
                    begin
                        state_q     <= ST_IDLE;
                        res_valid_q <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request hold and result capture
    always_ff @(posedge i_clk_pcie)
    begin
        if (mgmt.ack)
            req_q <= mgmt.req;
        else if (idle && i_fire)
            req_q <= auto_req;
        if (!idle && i_cfg_mgmt_rd_wr_done)
        begin
            mgmt.res_data <= i_cfg_mgmt_do;
            mgmt.res_addr <= req_q.dwaddr;
            mgmt.res_be   <= req_q.byte_en;
        end
    end

    // enables drop in the done cycle
    assign o_cfg_mgmt_rd_en         = (state_q == ST_READ) & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_wr_en         = (state_q == ST_WRITE) & ~i_cfg_mgmt_rd_wr_done;
    assign o_cfg_mgmt_di            = req_q.di;
    assign o_cfg_mgmt_dwaddr        = req_q.dwaddr;
    assign o_cfg_mgmt_byte_en       = req_q.byte_en;
    assign o_cfg_mgmt_wr_readonly   = req_q.wr_readonly;
    assign o_cfg_mgmt_wr_rw1c_as_rw = req_q.rw1c_as_rw;

endmodule

`default_nettype wire

// ==== hdl/pcie_cfg_mgmt_if.sv ====
// request/result channel between register file and cfg_mgmt engine
`default_nettype none
`include "pcie_cfg_defs.svh"

interface pcie_cfg_mgmt_if import pcie_cfg_mgmt_pkg::*; ();

    mgmt_op_e                 req_op;       // held until ack
    mgmt_req_t                req;          // address, data, byte enables
    logic                     ack;          // request taken this cycle
    logic [`CFG_DATA_W-1:0]   res_data;     // captured cfg_mgmt_do
    logic [`CFG_DWADDR_W-1:0] res_addr;
    logic [`CFG_BE_W-1:0]     res_be;
    logic                     res_valid;    // result matches last access
    logic                     busy;         // access in flight

    // register file side
    modport regs (
        output req_op, req,
        input  ack, res_data, res_addr, res_be, res_valid, busy
    );

    // engine side
    modport seq (
        input  req_op, req,
        output ack, res_data, res_addr, res_be, res_valid, busy
    );

endinterface

`default_nettype wire

// ==== hdl/pcie_cfg_mgmt_pkg.sv ====
// cfg_mgmt request, opcode and engine state types
`default_nettype none
`include "pcie_cfg_defs.svh"

package pcie_cfg_mgmt_pkg;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mgmt_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,                            // rd_en held until done
        ST_WRITE = 2'd2                             // wr_en held until done
    } mgmt_state_e;

    // one single-dword access, 48 bits
    typedef struct packed {
        logic [`CFG_DWADDR_W-1:0] dwaddr;
        logic [`CFG_DATA_W-1:0]   di;
        logic [`CFG_BE_W-1:0]     byte_en;
        logic                     wr_readonly;      // write ro fields too
        logic                     rw1c_as_rw;       // treat rw1c as plain rw
    } mgmt_req_t;

endpackage

`default_nettype wire

// ==== hdl/pcie_cfg_reg_pkg.sv ====
// host visible register map: word offsets and control layout
`default_nettype none

package pcie_cfg_reg_pkg;

    // byte offsets of the 32-bit register words
    typedef enum logic [7:0] {
        REG_ID           = 8'h00,   // ro magic
        REG_CTRL         = 8'h04,   // start bits + auto write enables
        REG_MGMT_DI      = 8'h08,   // write data for cfg_mgmt
        REG_MGMT_ADDR    = 8'h0C,   // dwaddr 9:0, ro 10, rw1c 11, be 15:12
        REG_CLEAR_PERIOD = 8'h10,   // timer period in clocks
        REG_RESULT_DATA  = 8'h14,   // ro, last cfg_mgmt_do
        REG_RESULT_INFO  = 8'h18,   // ro, addr 9:0, be 15:12, valid 16, busy 17
        REG_PCIE_ID      = 8'h1C    // ro, bus/dev/func 15:0
    } reg_addr_e;

    // CTRL word, bits 3:0
    typedef struct packed {
        logic command_set_en;       // bit 3, auto set of command bits
        logic status_clear_en;      // bit 2, auto clear of status flags
        logic wr_start;             // bit 1, write 1 to start, held until ack
        logic rd_start;             // bit 0, write 1 to start, held until ack
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pcie_cfg_regfile.sv ====
// apb slave register file: control, cfg_mgmt request fields, period,
// result and id readback
`default_nettype none
`include "pcie_cfg_defs.svh"

module pcie_cfg_regfile import pcie_cfg_reg_pkg::*, pcie_cfg_mgmt_pkg::*; (
    input  wire                     i_clk_pcie,
    input  wire                     i_rst,
    input  wire                     i_psel,
    input  wire                     i_penable,
    input  wire                     i_pwrite,
    input  wire [`CFG_APB_AW-1:0]   i_paddr,
    input  wire [`CFG_DATA_W-1:0]   i_pwdata,
    output logic [`CFG_DATA_W-1:0]  o_prdata,
    input  wire [7:0]               i_cfg_bus_number,
    input  wire [4:0]               i_cfg_device_number,
    input  wire [2:0]               i_cfg_function_number,
    pcie_cfg_mgmt_if.regs           mgmt,
    output ctrl_t                   o_ctrl,
    output logic [`CFG_DATA_W-1:0]  o_clear_period
);

    ctrl_t                  ctrl_q;
    mgmt_req_t              req_q;          // MGMT_DI + MGMT_ADDR fields
    logic [`CFG_DATA_W-1:0] period_q;
    reg_addr_e              addr;
    logic                   apb_wr;
    logic                   ctrl_wr;
    logic                   rd_clr;
    logic                   wr_clr;

    assign addr    = reg_addr_e'(i_paddr);
    assign apb_wr  = i_psel & i_penable & i_pwrite;        // access phase, no waits
    assign ctrl_wr = apb_wr & (addr == REG_CTRL);

    // ------------------------------------------------------------
    // start bits to request
    // ------------------------------------------------------------
    always_comb
    begin
        if (ctrl_q.rd_start)
            mgmt.req_op = OP_READ;                         // read wins a tie
        else if (ctrl_q.wr_start)
            mgmt.req_op = OP_WRITE;
        else
            mgmt.req_op = OP_NONE;
    end

    assign mgmt.req = req_q;
    assign rd_clr   = mgmt.ack & (mgmt.req_op == OP_READ);
    assign wr_clr   = mgmt.ack & (mgmt.req_op == OP_WRITE);

    // ------------------------------------------------------------
    // register writes
    // ------------------------------------------------------------
    always_ff @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            ctrl_q              <= '0;
            req_q.dwaddr        <= '0;
            req_q.di            <= '0;
            req_q.byte_en       <= `CFG_BE_RESET;
            req_q.wr_readonly   <= 1'b0;
            req_q.rw1c_as_rw    <= 1'b0;
            period_q            <= `CFG_CLEAR_PERIOD_DEFAULT;
        end
        else
        begin
            // a fresh start written on the ack edge survives the clear
            ctrl_q.rd_start <= (ctrl_q.rd_start & ~rd_clr) | (ctrl_wr & i_pwdata[0]);
            ctrl_q.wr_start <= (ctrl_q.wr_start & ~wr_clr) | (ctrl_wr & i_pwdata[1]);
            if (ctrl_wr)
            begin
                ctrl_q.status_clear_en <= i_pwdata[2];
                ctrl_q.command_set_en  <= i_pwdata[3];
            end
            if (apb_wr)
            begin
                case (addr)
                    REG_MGMT_DI:      req_q.di <= i_pwdata;
                    REG_MGMT_ADDR:
                    begin
                        req_q.dwaddr      <= i_pwdata[9:0];
                        req_q.wr_readonly <= i_pwdata[10];
                        req_q.rw1c_as_rw  <= i_pwdata[11];
                        req_q.byte_en     <= i_pwdata[15:12];
                    end
                    REG_CLEAR_PERIOD: period_q <= i_pwdata;
                    default:          ;                    // ro words ignore writes
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // readback mux
    // ------------------------------------------------------------
    always_comb
    begin
        case (addr)
            REG_ID:           o_prdata = `CFG_MAGIC;
            REG_CTRL:         o_prdata = {28'd0, ctrl_q};
            REG_MGMT_DI:      o_prdata = req_q.di;
            REG_MGMT_ADDR:    o_prdata = {16'd0, req_q.byte_en, req_q.rw1c_as_rw,
                                          req_q.wr_readonly, req_q.dwaddr};
            REG_CLEAR_PERIOD: o_prdata = period_q;
            REG_RESULT_DATA:  o_prdata = mgmt.res_data;
            REG_RESULT_INFO:  o_prdata = {14'd0, mgmt.busy, mgmt.res_valid,
                                          mgmt.res_be, 2'd0, mgmt.res_addr};
            REG_PCIE_ID:      o_prdata = {16'd0, i_cfg_bus_number, i_cfg_device_number,
                                          i_cfg_function_number};
            default:          o_prdata = '0;           // unmapped offset
        endcase
    end

    assign o_ctrl         = ctrl_q;
    assign o_clear_period = period_q;

endmodule

`default_nettype wire

// ==== hdl/pcie_cfg_top.sv ====
// configuration space management top: register file, cfg_mgmt engine,
// auto write timer
`default_nettype none
`include "pcie_cfg_defs.svh"

module pcie_cfg_top import pcie_cfg_reg_pkg::*; (
    input  wire                       clk_pcie,
    input  wire                       rst,
    // apb slave
    input  wire                       i_psel,
    input  wire                       i_penable,
    input  wire                       i_pwrite,
    input  wire [`CFG_APB_AW-1:0]     i_paddr,
    input  wire [`CFG_DATA_W-1:0]     i_pwdata,
    output wire [`CFG_DATA_W-1:0]     o_prdata,
    output wire                       o_pready,
    output wire                       o_pslverr,
    // cfg_mgmt port of the pcie core
    output wire                       o_cfg_mgmt_rd_en,
    output wire                       o_cfg_mgmt_wr_en,
    output wire [`CFG_DATA_W-1:0]     o_cfg_mgmt_di,
    output wire [`CFG_DWADDR_W-1:0]   o_cfg_mgmt_dwaddr,
    output wire [`CFG_BE_W-1:0]       o_cfg_mgmt_byte_en,
    output wire                       o_cfg_mgmt_wr_readonly,
    output wire                       o_cfg_mgmt_wr_rw1c_as_rw,
    input  wire                       i_cfg_mgmt_rd_wr_done,
    input  wire [`CFG_DATA_W-1:0]     i_cfg_mgmt_do,
    // id from the core
    input  wire [7:0]                 i_cfg_bus_number,
    input  wire [4:0]                 i_cfg_device_number,
    input  wire [2:0]                 i_cfg_function_number
);

    ctrl_t                  ctrl;
    wire [`CFG_DATA_W-1:0]  clear_period;
    wire                    quiet;
    wire                    fire;

    assign o_pready  = 1'b1;                        // zero wait states
    assign o_pslverr = 1'b0;

    pcie_cfg_mgmt_if mgmt ();

    pcie_cfg_regfile u_regfile (
        .i_clk_pcie            (clk_pcie),
        .i_rst                 (rst),
        .i_psel                (i_psel),
        .i_penable             (i_penable),
        .i_pwrite              (i_pwrite),
        .i_paddr               (i_paddr),
        .i_pwdata              (i_pwdata),
        .o_prdata              (o_prdata),
        .i_cfg_bus_number      (i_cfg_bus_number),
        .i_cfg_device_number   (i_cfg_device_number),
        .i_cfg_function_number (i_cfg_function_number),
        .mgmt                  (mgmt.regs),
        .o_ctrl                (ctrl),
        .o_clear_period        (clear_period)
    );

    pcie_cfg_mgmt_fsm u_fsm (
        .i_clk_pcie               (clk_pcie),
        .i_rst                    (rst),
        .mgmt                     (mgmt.seq),
        .i_fire                   (fire),
        .i_ctrl                   (ctrl),
        .o_quiet                  (quiet),
        .o_cfg_mgmt_rd_en         (o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en         (o_cfg_mgmt_wr_en),
        .o_cfg_mgmt_di            (o_cfg_mgmt_di),
        .o_cfg_mgmt_dwaddr        (o_cfg_mgmt_dwaddr),
        .o_cfg_mgmt_byte_en       (o_cfg_mgmt_byte_en),
        .o_cfg_mgmt_wr_readonly   (o_cfg_mgmt_wr_readonly),
        .o_cfg_mgmt_wr_rw1c_as_rw (o_cfg_mgmt_wr_rw1c_as_rw),
        .i_cfg_mgmt_rd_wr_done    (i_cfg_mgmt_rd_wr_done),
        .i_cfg_mgmt_do            (i_cfg_mgmt_do)
    );

    pcie_cfg_clear_timer u_timer (
        .i_clk_pcie (clk_pcie),
        .i_rst      (rst),
        .i_enable   (ctrl.status_clear_en | ctrl.command_set_en),
        .i_quiet    (quiet),
        .i_period   (clear_period),
        .o_fire     (fire)
    );

endmodule

`default_nettype wire

// ==== pcie_cfg_top.f ====
+incdir+hdl
hdl/pcie_cfg_reg_pkg.sv
hdl/pcie_cfg_mgmt_pkg.sv
hdl/pcie_cfg_mgmt_if.sv
hdl/pcie_cfg_regfile.sv
hdl/pcie_cfg_mgmt_fsm.sv
hdl/pcie_cfg_clear_timer.sv
hdl/pcie_cfg_top.sv
test/pcie_cfg_core_model.sv
test/tb_pcie_cfg_top.sv

// ==== test/pcie_cfg_core_model.sv ====
// behavioral pcie core config space, 64 dwords, answers cfg_mgmt accesses
`default_nettype none

module pcie_cfg_core_model (
    input  wire         i_clk_pcie,
    input  wire         i_rst,
    input  wire         i_rd_en,
    input  wire         i_wr_en,
    input  wire [31:0]  i_di,
    input  wire [9:0]   i_dwaddr,
    input  wire [3:0]   i_byte_en,
    output logic        o_done,
    output logic [31:0] o_do
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [31:0] mem [0:63];
    logic [1:0]  wait_q;                            // cycles since enable rose
    logic [5:0]  idx;
    integer      i;
    integer      b;

    assign idx = i_dwaddr[5:0];                     // upper address bits alias

    // fill: dword index in bytes 3 and 1, fixed marks in bytes 2 and 0
    initial
    begin
        for (i = 0; i < 64; i = i + 1)
            mem[i] = {2'b00, i[5:0], 8'hC3, 2'b00, i[5:0], 8'h3C};
    end

    always @(posedge i_clk_pcie)
    begin
        if (i_rst)
        begin
            o_done <= 1'b0;
            o_do   <= '0;
            wait_q <= '0;
        end
        else if (o_done)
        begin
            o_done <= 1'b0;                         // one cycle pulse
            wait_q <= '0;
        end
        else if (i_rd_en || i_wr_en)
        begin
            if (wait_q == 2'd2)
            begin
                o_done <= 1'b1;                     // third edge after enable rose
                if (i_rd_en)
                    o_do <= mem[idx];
                else
                    for (b = 0; b < 4; b = b + 1)
                        if (i_byte_en[b])
                            mem[idx][8*b +: 8] <= i_di[8*b +: 8];  // byte merge
            end
            else
                wait_q <= wait_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_pcie_cfg_top.sv ====
// testbench for the config management top with clock, reset, apb tasks,
// stimulus table with checks and cycle limit
`default_nettype none
`include "pcie_cfg_defs.svh"

module tb_pcie_cfg_top import pcie_cfg_reg_pkg::*;;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PERIOD      = 100;
    localparam int AUTO_WAIT   = 100;                   // cycles of auto writes
    localparam int MAX_ENTRIES = 40;
    localparam int A_WRITE     = 0;                     // apb write
    localparam int A_READ      = 1;                     // apb read with data column as mask
    localparam int A_WAIT      = 2;                     // poll until result valid
    localparam int A_IDLE      = 3;                     // idle for data cycles
    localparam logic [7:0] BUS_NUM  = 8'h3A;
    localparam logic [4:0] DEV_NUM  = 5'h11;
    localparam logic [2:0] FUNC_NUM = 3'h5;

    logic        clk_pcie;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         rd_en;
    wire         wr_en;
    wire  [31:0] mgmt_di;
    wire  [9:0]  mgmt_dwaddr;
    wire  [3:0]  mgmt_be;
    wire         mgmt_ro;
    wire         mgmt_rw1c;
    wire         mgmt_done;
    wire  [31:0] mgmt_do;

    string       t_name [MAX_ENTRIES];
    int          t_op   [MAX_ENTRIES];
    logic [7:0]  t_addr [MAX_ENTRIES];
    logic [31:0] t_data [MAX_ENTRIES];
    logic [31:0] t_exp  [MAX_ENTRIES];
    int          n_entries   = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    integer      seed;
    logic [31:0] rdata;
    logic [1:0]  exp_flags;                             // rw1c and ro of last MGMT_ADDR

    pcie_cfg_top UUT (
        .clk_pcie (clk_pcie), .rst (rst),
        .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
        .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata),
        .o_pready (pready), .o_pslverr (pslverr),
        .o_cfg_mgmt_rd_en (rd_en), .o_cfg_mgmt_wr_en (wr_en),
        .o_cfg_mgmt_di (mgmt_di), .o_cfg_mgmt_dwaddr (mgmt_dwaddr),
        .o_cfg_mgmt_byte_en (mgmt_be), .o_cfg_mgmt_wr_readonly (mgmt_ro),
        .o_cfg_mgmt_wr_rw1c_as_rw (mgmt_rw1c),
        .i_cfg_mgmt_rd_wr_done (mgmt_done), .i_cfg_mgmt_do (mgmt_do),
        .i_cfg_bus_number (BUS_NUM), .i_cfg_device_number (DEV_NUM),
        .i_cfg_function_number (FUNC_NUM)
    );

    pcie_cfg_core_model u_core (
        .i_clk_pcie (clk_pcie), .i_rst (rst),
        .i_rd_en (rd_en), .i_wr_en (wr_en), .i_di (mgmt_di),
        .i_dwaddr (mgmt_dwaddr), .i_byte_en (mgmt_be),
        .o_done (mgmt_done), .o_do (mgmt_do)
    );

    initial
    begin
        clk_pcie = 1'b0;
        forever #(PERIOD / 2) clk_pcie = ~clk_pcie;
    end

    // run limit
    always @(posedge clk_pcie)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
        begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // cfg_mgmt write flags while an access is held
    // ------------------------------------------------------------
    always @(posedge clk_pcie)
    begin
        if (rst)
            exp_flags <= 2'b00;
        else if (psel && penable && pwrite && paddr == REG_MGMT_ADDR)
            exp_flags <= pwdata[11:10];                 // bits 11:10 of the written word
    end

    always @(negedge clk_pcie)
    begin
        if (wr_en && mgmt_dwaddr == `CFG_CMDSTAT_DWADDR)
        begin
            // auto write never uses ro or rw1c
            if ({mgmt_rw1c, mgmt_ro} !== 2'b00)
            begin
                $display("Fail auto_flags: expected %b, actual %b", 2'b00,
                         {mgmt_rw1c, mgmt_ro});
                errors++;
            end
        end
        else if (rd_en || wr_en)
        begin
            if ({mgmt_rw1c, mgmt_ro} !== exp_flags)
            begin
                $display("Fail host_flags: expected %b, actual %b", exp_flags,
                         {mgmt_rw1c, mgmt_ro});
                errors++;
            end
        end
    end

    // ------------------------------------------------------------
    // apb access tasks driving inputs on the falling edge
    // ------------------------------------------------------------
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk_pcie);
        psel    = 1'b1;                                 // setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_pcie);
        penable = 1'b1;                                 // access phase
        @(negedge clk_pcie);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk_pcie);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk_pcie);
        penable = 1'b1;
        #(PERIOD / 4);                                  // mid access phase where prdata is stable
        data = prdata;
        if (!pready || pslverr)
        begin
            $display("apb read of offset %h gave no ready or a slave error", addr);
            errors++;
        end
        @(negedge clk_pcie);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // poll RESULT_INFO until valid and not busy
    task automatic wait_result();
        logic [31:0] info;
        info = '0;
        while (!(info[16] && !info[17]))
            apb_read(REG_RESULT_INFO, info);
    endtask

    task automatic add_entry(input string name, input int op, input logic [7:0] addr,
                             input logic [31:0] data, input logic [31:0] exp);
        t_name[n_entries] = name;
        t_op[n_entries]   = op;
        t_addr[n_entries] = addr;
        t_data[n_entries] = data;
        t_exp[n_entries]  = exp;
        n_entries++;
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    task automatic build_table();
        logic [31:0] rnd;
        add_entry("reset_id", A_READ, REG_ID, 32'hFFFF_FFFF, `CFG_MAGIC);
        add_entry("reset_addr", A_READ, REG_MGMT_ADDR, 32'hFFFF_FFFF, 32'h0000_F000);
        add_entry("reset_period", A_READ, REG_CLEAR_PERIOD, 32'hFFFF_FFFF,
                  `CFG_CLEAR_PERIOD_DEFAULT);
        add_entry("reset_info", A_READ, REG_RESULT_INFO, 32'h0003_0000, 32'h0);
        rnd = $random(seed);
        add_entry("di_wr", A_WRITE, REG_MGMT_DI, rnd, 32'h0);
        add_entry("di_rd", A_READ, REG_MGMT_DI, 32'hFFFF_FFFF, rnd);
        rnd = $random(seed);
        add_entry("addr_wr", A_WRITE, REG_MGMT_ADDR, rnd, 32'h0);
        add_entry("addr_rd", A_READ, REG_MGMT_ADDR, 32'hFFFF_FFFF, {16'd0, rnd[15:0]});
        rnd = $random(seed);
        add_entry("period_wr", A_WRITE, REG_CLEAR_PERIOD, rnd, 32'h0);
        add_entry("period_rd", A_READ, REG_CLEAR_PERIOD, 32'hFFFF_FFFF, rnd);
        add_entry("id_wr", A_WRITE, REG_ID, 32'hFFFF_FFFF, 32'h0);
        add_entry("id_rd", A_READ, REG_ID, 32'hFFFF_FFFF, `CFG_MAGIC);
        // config read of dword 5 with all bytes
        add_entry("rd5_addr", A_WRITE, REG_MGMT_ADDR, 32'h0000_F005, 32'h0);
        add_entry("rd5_start", A_WRITE, REG_CTRL, 32'h1, 32'h0);
        add_entry("rd5_wait", A_WAIT, REG_RESULT_INFO, 32'h0, 32'h0);
        add_entry("rd5_data", A_READ, REG_RESULT_DATA, 32'hFFFF_FFFF, 32'h05C3_053C);
        add_entry("rd5_info", A_READ, REG_RESULT_INFO, 32'h0003_F3FF, 32'h0001_F005);
        // partial write of dword 9 on bytes 0 and 2 then read back
        add_entry("wr9_di", A_WRITE, REG_MGMT_DI, 32'hAABB_CCDD, 32'h0);
        add_entry("wr9_addr", A_WRITE, REG_MGMT_ADDR, 32'h0000_5C09, 32'h0);
        add_entry("wr9_start", A_WRITE, REG_CTRL, 32'h2, 32'h0);
        add_entry("wr9_wait", A_WAIT, REG_RESULT_INFO, 32'h0, 32'h0);
        add_entry("rd9_addr", A_WRITE, REG_MGMT_ADDR, 32'h0000_FC09, 32'h0);
        add_entry("rd9_start", A_WRITE, REG_CTRL, 32'h1, 32'h0);
        add_entry("rd9_wait", A_WAIT, REG_RESULT_INFO, 32'h0, 32'h0);
        add_entry("rd9_data", A_READ, REG_RESULT_DATA, 32'hFFFF_FFFF, 32'h09BB_09DD);
        // auto command set only then a read of the command/status dword
        add_entry("auto_period", A_WRITE, REG_CLEAR_PERIOD, 32'd20, 32'h0);
        add_entry("auto_on", A_WRITE, REG_CTRL, 32'h8, 32'h0);
        add_entry("auto_run", A_IDLE, REG_ID, AUTO_WAIT, 32'h0);
        add_entry("auto_off", A_WRITE, REG_CTRL, 32'h0, 32'h0);
        add_entry("rd1_addr", A_WRITE, REG_MGMT_ADDR, 32'h0000_F001, 32'h0);
        add_entry("rd1_start", A_WRITE, REG_CTRL, 32'h1, 32'h0);
        add_entry("rd1_wait", A_WAIT, REG_RESULT_INFO, 32'h0, 32'h0);
        add_entry("rd1_data", A_READ, REG_RESULT_DATA, 32'hFFFF_FFFF,
                  {16'h01C3, `CFG_CMD_SET_BITS});
        add_entry("pcie_id", A_READ, REG_PCIE_ID, 32'hFFFF_FFFF,
                  {16'd0, BUS_NUM, DEV_NUM, FUNC_NUM});
    endtask

    initial
    begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 3;
        build_table();
        cycle_limit = n_entries * 40 + 2 * AUTO_WAIT;
        repeat (10) @(negedge clk_pcie);
        rst = 1'b0;
        for (int k = 0; k < n_entries; k++)
        begin
            case (t_op[k])
                A_WRITE: apb_write(t_addr[k], t_data[k]);
                A_WAIT:  wait_result();
                A_IDLE:  repeat (t_data[k]) @(negedge clk_pcie);
                default:
                begin
                    apb_read(t_addr[k], rdata);
                    checks++;
                    if ((rdata & t_data[k]) !== (t_exp[k] & t_data[k]))
                    begin
                        $display("Fail %s: expected %h, actual %h", t_name[k],
                                 t_exp[k] & t_data[k], rdata & t_data[k]);
                        errors++;
                    end
                end
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
